// ==== source/arb_defines.svh ====
/*
  Build-wide constants for the shared-sink arbitration subsystem.
  Include wherever the client count, byte width or LFSR seed is needed.
*/
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// Clients sharing the sink
`define ARB_NUM_CLIENTS 4

`define ARB_DATA_W 8 // Bits per transfer

// Stage 1 set, stages 2 and 3 clear
`define ARB_LFSR_SEED 3'b001

`endif

// ==== source/arb_pkg.sv ====
/*
  Arbitration types: the scheme select and the client index.
  Imported by the arbiter and the sink, and by the testbench.
*/
`default_nettype none

`include "arb_defines.svh"

package arb_pkg;

  // Codes 6 and 7 are left unnamed and give no grant
  typedef enum logic [2:0] {
    fix0        = 3'd0,
    fix1        = 3'd1,
    fix2        = 3'd2,
    fix3        = 3'd3,
    round_robin = 3'd4,
    pseudo_rand = 3'd5
  } arb_mode_e;

  typedef logic [$clog2(`ARB_NUM_CLIENTS)-1:0] client_id_t;

  // One-hot (or zero) grant to client index
  function automatic client_id_t onehot_to_id(input logic [`ARB_NUM_CLIENTS-1:0] oh);
    client_id_t id;
    id = '0;
    for (int i = 0; i < `ARB_NUM_CLIENTS; i++) begin
      if (oh[i]) id = client_id_t'(i);
    end
    return id;
  endfunction

endpackage

`default_nettype wire

// ==== source/xfer_pkg.sv ====
/*
  Transfer types: client port handshake states and the payload byte.
  Imported by the client ports, the sink and the top level.
*/
`default_nettype none

`include "arb_defines.svh"

package xfer_pkg;

  typedef enum logic [1:0] {
    idle,    // No request outstanding
    waiting, // Request raised toward the arbiter
    acked    // Served, holding ack until req_in drops
  } port_state_e;

  typedef logic [`ARB_DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// ==== source/pn_seq_gen.sv ====
/*
  Three-stage Fibonacci LFSR stepping every cycle from reset.
  Its top two stages name the preferred client for pseudo-random arbitration.
*/
`default_nettype none
`timescale 1ns/1ps

`include "arb_defines.svh"

module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] rand_sel
);

  // Bit 0 is stage 1, bit 2 is stage 3
  logic [2:0] lfsr;
  logic       fb;

  assign fb = lfsr[0] ^ lfsr[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= `ARB_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[1:0], fb}; // Shift toward stage 3
    end
  end

  assign rand_sel = lfsr[2:1]; // Stages 3 and 2

endmodule

`default_nettype wire

// ==== source/arbiter.sv ====
/*
  Four-way arbiter with six selectable schemes: fixed priority for any
  top client, round robin, and LFSR-chosen priority. The grant is registered
  and one-hot, one pulse per win; the client granted now is masked from
  the next decision so its dropping request is never seen twice.
*/
`default_nettype none
`timescale 1ns/1ps

`include "arb_defines.svh"

module arbiter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`ARB_NUM_CLIENTS-1:0] port_req,
  input  arb_pkg::arb_mode_e          arb_mode,
  input  logic [1:0]                  rand_sel,
  output logic [`ARB_NUM_CLIENTS-1:0] gnt
);

  import arb_pkg::*;

  logic [`ARB_NUM_CLIENTS-1:0] req_m;    // Requests minus current winner
  logic [`ARB_NUM_CLIENTS-1:0] gnt_fix;
  logic [`ARB_NUM_CLIENTS-1:0] gnt_rr;
  logic [`ARB_NUM_CLIENTS-1:0] gnt_px;
  logic [`ARB_NUM_CLIENTS-1:0] gnt_nxt;
  client_id_t                  rr_ptr;   // Last round-robin winner

  // Chosen client first, then the rest by index
  function automatic logic [`ARB_NUM_CLIENTS-1:0] prio_pick(
    input logic [`ARB_NUM_CLIENTS-1:0] req,
    input client_id_t                  first
  );
    logic [`ARB_NUM_CLIENTS-1:0] pick;
    pick = '0;
    for (int i = `ARB_NUM_CLIENTS - 1; i >= 0; i--) begin
      if (req[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
    if (req[first]) begin
      pick        = '0;
      pick[first] = 1'b1;
    end
    return pick;
  endfunction

  // First requester counting up from ptr + 1, with wrap
  function automatic logic [`ARB_NUM_CLIENTS-1:0] rr_pick(
    input logic [`ARB_NUM_CLIENTS-1:0] req,
    input client_id_t                  ptr
  );
    logic [`ARB_NUM_CLIENTS-1:0] pick;
    int                          idx;
    pick = '0;
    for (int i = `ARB_NUM_CLIENTS; i >= 1; i--) begin
      idx = (int'(ptr) + i) % `ARB_NUM_CLIENTS;
      if (req[idx]) begin
        pick      = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  assign req_m = port_req & ~gnt;

  assign gnt_fix = prio_pick(req_m, client_id_t'(arb_mode[1:0]));
  assign gnt_rr  = rr_pick(req_m, rr_ptr);
  assign gnt_px  = prio_pick(req_m, client_id_t'(rand_sel));

  always_comb begin
    case (arb_mode)
      fix0, fix1, fix2, fix3: gnt_nxt = gnt_fix;
      round_robin:            gnt_nxt = gnt_rr;
      pseudo_rand:            gnt_nxt = gnt_px;
      default:                gnt_nxt = '0; // Unnamed codes hold everyone off
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt    <= '0;
      rr_ptr <= client_id_t'(`ARB_NUM_CLIENTS - 1); // Client 0 goes first
    end else begin
      gnt <= gnt_nxt;
      if (arb_mode == round_robin && |gnt_rr) begin
        rr_ptr <= onehot_to_id(gnt_rr);
      end
    end
  end

  a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(gnt));

  // A grant only goes to a port that was asking
  a_gnt_had_req: assert property (@(posedge clk) disable iff (!rst_n)
    (gnt & ~$past(port_req)) == '0);

  // In fix0 nobody below the winner was still eligible
  a_fix0_order: assert property (@(posedge clk) disable iff (!rst_n)
    (|gnt && $past(arb_mode == fix0)) |-> ((gnt - 1'b1) & $past(req_m)) == '0);

endmodule

`default_nettype wire

// ==== source/client_port.sv ====
/*
  One client's side of the shared sink. Converts the external four-phase
  req/ack handshake into a level request for the arbiter and holds the
  offered byte until the sink has taken it.
*/
`default_nettype none
`timescale 1ns/1ps

`include "arb_defines.svh"

module client_port (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_in,
  input  xfer_pkg::data_t data_in,
  input  logic            gnt,
  output logic            ack,
  output logic            port_req,
  output xfer_pkg::data_t data_held
);

  import xfer_pkg::*;

  port_state_e state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (req_in) state <= waiting;
        end
        waiting: begin
          if (gnt) state <= acked; // Sink takes the byte on this edge
        end
        acked: begin
          // Held request keeps ack up, no second transfer
          if (!req_in) state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Data is stable while req_in is high and ack low
  always_ff @(posedge clk) begin
    if (state == idle && req_in) begin
      data_held <= data_in;
    end
  end

  assign port_req = (state == waiting);
  assign ack      = (state == acked);

  a_gnt_when_waiting: assert property (@(posedge clk) disable iff (!rst_n)
    gnt |-> state == waiting);

endmodule

`default_nettype wire

// ==== source/xfer_sink.sv ====
/*
  Shared transfer sink. In the cycle after a grant it presents the winning
  port's byte and id with a one-cycle valid.
*/
`default_nettype none
`timescale 1ns/1ps

`include "arb_defines.svh"

module xfer_sink (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`ARB_NUM_CLIENTS-1:0] gnt,
  input  xfer_pkg::data_t             data_held [`ARB_NUM_CLIENTS],
  output logic                        out_valid,
  output arb_pkg::client_id_t         out_id,
  output xfer_pkg::data_t             out_data
);

  import arb_pkg::*;

  client_id_t gnt_id;

  assign gnt_id = onehot_to_id(gnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |gnt;
    end
  end

  // Payload only meaningful with out_valid
  always_ff @(posedge clk) begin
    if (|gnt) begin
      out_id   <= gnt_id;
      out_data <= data_held[gnt_id];
    end
  end

  // Back-to-back transfers never come from the same port
  a_no_repeat_id: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && $past(out_valid)) |-> (out_id != $past(out_id)));

endmodule

`default_nettype wire

// ==== source/arb_subsys.sv ====
/*
  Top level of the shared-sink subsystem. Four client ports feed the
  arbiter, the LFSR supplies the pseudo-random preference, and the sink
  presents each winner's byte and id.
*/
`default_nettype none
`timescale 1ns/1ps

`include "arb_defines.svh"

module arb_subsys (
  input  logic                        clk,
  input  logic                        rst_n,
  input  arb_pkg::arb_mode_e          arb_mode,
  input  logic [`ARB_NUM_CLIENTS-1:0] req_in,
  input  xfer_pkg::data_t             data_in [`ARB_NUM_CLIENTS],
  output logic [`ARB_NUM_CLIENTS-1:0] ack,
  output logic                        out_valid,
  output arb_pkg::client_id_t         out_id,
  output xfer_pkg::data_t             out_data
);

  import xfer_pkg::*;

  logic [`ARB_NUM_CLIENTS-1:0] port_req;
  logic [`ARB_NUM_CLIENTS-1:0] gnt;
  logic [1:0]                  rand_sel;
  data_t                       data_held [`ARB_NUM_CLIENTS];

  pn_seq_gen u_lfsr (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_sel (rand_sel)
  );

  arbiter u_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .port_req (port_req),
    .arb_mode (arb_mode),
    .rand_sel (rand_sel),
    .gnt      (gnt)
  );

  for (genvar i = 0; i < `ARB_NUM_CLIENTS; i++) begin : g_port
    client_port u_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_in    (req_in[i]),
      .data_in   (data_in[i]),
      .gnt       (gnt[i]),
      .ack       (ack[i]),
      .port_req  (port_req[i]),
      .data_held (data_held[i])
    );
  end

  xfer_sink u_sink (
    .clk       (clk),
    .rst_n     (rst_n),
    .gnt       (gnt),
    .data_held (data_held),
    .out_valid (out_valid),
    .out_id    (out_id),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// ==== dv/tb_arb_subsys.sv ====
/*
  Self-checking testbench for the shared-sink arbitration subsystem.
  Each stimulus line is one burst of client requests; served ids and bytes
  are compared with the order in the file, and every handshake is closed.
*/
`default_nettype none
`timescale 1ns/1ps

`include "arb_defines.svh"

module tb_arb_subsys;

  import arb_pkg::*;

  localparam int N        = `ARB_NUM_CLIENTS;
  localparam int COLS     = 10; // Mode, mask, 4 bytes, 4 ids
  localparam int MAX_ROWS = 64;
  localparam int TIMEOUT  = 100;

  logic                  clk;
  logic                  rst_n;
  arb_mode_e             arb_mode;
  logic [N-1:0]          req_in;
  logic [`ARB_DATA_W-1:0] data_in [N];
  logic [N-1:0]          ack;
  logic                  out_valid;
  client_id_t            out_id;
  logic [`ARB_DATA_W-1:0] out_data;

  logic [7:0] stim [MAX_ROWS*COLS];
  int         errors  = 0;
  int         checks  = 0;
  bit         aborted = 1'b0;

  arb_subsys dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .arb_mode  (arb_mode),
    .req_in    (req_in),
    .data_in   (data_in),
    .ack       (ack),
    .out_valid (out_valid),
    .out_id    (out_id),
    .out_data  (out_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  task automatic run_burst(input int row);
    int           base;
    logic [7:0]   mode_b;
    logic [N-1:0] mask;
    logic [N-1:0] served;
    logic [N-1:0] ack_seen;
    logic [N-1:0] dropped;
    int           hold [N];
    int           drop_age [N];
    int           n_served;
    int           n_expected;
    int           edges;
    int           waited;
    bit           single;
    bit           set_only;
    bit           done;
    base       = row * COLS;
    mode_b     = stim[base];
    mask       = stim[base + 1][N-1:0];
    n_expected = $countones(mask);
    single     = (n_expected == 1) && (mode_b[7:4] == 4'h0);
    set_only   = (stim[base + 6] == 8'hee); // Pseudo-random lines
    served     = '0;
    ack_seen   = '0;
    dropped    = '0;
    n_served   = 0;
    edges      = 0;
    waited     = 0;
    done       = 1'b0;
    for (int i = 0; i < N; i++) begin
      hold[i]     = $urandom_range(0, 3);
      drop_age[i] = 0;
    end

    @(posedge clk);
    for (int i = 0; i < N; i++) data_in[i] <= stim[base + 2 + i];
    req_in <= mask;
    if (mode_b[7:4] != 4'h0) begin
      // Invalid code first, nothing may move
      arb_mode <= arb_mode_e'(mode_b[6:4]);
      repeat (6) begin
        @(negedge clk);
        check_eq("ack", ack, '0);
        check_eq("out_valid", out_valid, 1'b0);
      end
      @(posedge clk);
    end
    arb_mode <= arb_mode_e'(mode_b[2:0]);

    while (!done) begin
      @(negedge clk);
      waited++;
      if (out_valid) begin
        if (n_served >= n_expected || !mask[out_id] || served[out_id]) begin
          report_failure($sformatf("unexpected transfer from client %0d", out_id));
        end else begin
          if (!set_only) check_eq("out_id", out_id, stim[base + 6 + n_served]);
          check_eq("out_data", out_data, stim[base + 2 + out_id]);
          served[out_id] = 1'b1;
          n_served++;
        end
      end
      for (int i = 0; i < N; i++) begin
        if (ack[i] && !ack_seen[i]) begin
          ack_seen[i] = 1'b1;
          if (!mask[i]) report_failure($sformatf("ack from idle client %0d", i));
          check_eq("out_valid with ack", out_valid, 1'b1);
          check_eq("out_id with ack", out_id, i);
          if (single) check_eq("ack latency", edges, 3);
        end else if (ack_seen[i]) begin
          if (dropped[i]) drop_age[i]++;
          check_eq($sformatf("ack[%0d]", i), ack[i], !dropped[i] || drop_age[i] < 2);
        end
        if (ack_seen[i] && !dropped[i]) begin
          if (hold[i] == 0) dropped[i] = 1'b1; // Release on next edge
          else hold[i]--;
        end
      end
      done = (n_served == n_expected) && (dropped == mask) && (ack == '0);
      if (!done && waited > TIMEOUT) begin
        report_failure($sformatf("timeout, burst on stimulus row %0d never completed", row));
        aborted = 1'b1;
        done    = 1'b1;
      end
      if (!done) begin
        @(posedge clk);
        edges++;
        req_in <= mask & ~dropped;
      end
    end
  endtask

  initial begin
    int row;
    void'($urandom(31194));
    rst_n    = 1'b0;
    arb_mode = fix0;
    req_in   = '0;
    for (int i = 0; i < N; i++) data_in[i] = '0;
    $readmemh("dv/arb_stimulus.txt", stim);

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("ack", ack, '0);
    check_eq("out_valid", out_valid, 1'b0);

    row = 0;
    while (!aborted && row < MAX_ROWS && stim[row * COLS] != 8'hff) begin
      run_burst(row);
      repeat ($urandom_range(0, 4)) @(posedge clk); // Idle gap
      row++;
    end

    $display("bursts %0d, checks %0d, errors %0d", row, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/arb_pkg.sv
source/xfer_pkg.sv
source/pn_seq_gen.sv
source/arbiter.sv
source/client_port.sv
source/xfer_sink.sv
source/arb_subsys.sv
dv/tb_arb_subsys.sv

// ==== Makefile ====
# Verilator build and run for the shared-sink arbitration subsystem

VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_arb_subsys
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/arb_stimulus.txt ====
// Columns: mode, request mask, bytes for clients 0 to 3, service order as client ids
// Mode high nibble 6 or 7 stalls in that code first; order ee is any order; ff unused or end
// Fixed priority, all four clients
00 0f 11 22 33 44 00 01 02 03
01 0f a1 b2 c3 d4 01 00 02 03
02 0f 5a 6b 7c 8d 02 00 01 03
03 0f 0e 1d 2c 3b 03 00 01 02
// Fixed priority, partial masks
00 0a 90 91 92 93 01 03 ff ff
03 06 e0 e1 e2 e3 01 02 ff ff
02 0d 40 41 42 43 02 00 03 ff
01 05 77 66 55 44 00 02 ff ff
// Uncontended requests
00 04 00 00 c5 00 02 ff ff ff
03 01 3c 00 00 00 00 ff ff ff
01 02 00 e7 00 00 01 ff ff ff
05 08 00 00 00 9e 03 ff ff ff
// Round robin, pointer is 3 after reset
04 0f 10 20 30 40 00 01 02 03
04 05 a0 b0 c0 d0 00 02 ff ff
04 0b 1a 2b 3c 4d 03 00 01 ff
04 06 f1 f2 f3 f4 02 01 ff ff
04 08 00 00 00 88 03 ff ff ff
04 07 31 32 33 34 00 01 02 ff
04 09 c1 00 00 c4 03 00 ff ff
04 0e 00 d1 d2 d3 01 02 03 ff
// Pseudo-random, set only
05 0f 61 62 63 64 ee ee ee ee
05 0b 71 72 00 74 ee ee ee ee
05 06 00 81 82 00 ee ee ee ee
05 0f fe dc ba 98 ee ee ee ee
// Invalid mode first, then fixed priority
60 0f 13 24 35 46 00 01 02 03
73 07 57 68 79 00 00 01 02 ff
71 0c 00 00 aa bb 02 03 ff ff
62 0e 00 c7 d8 e9 02 01 03 ff
// End of stimulus
ff 00 00 00 00 00 ff ff ff ff
